// ==== led_matrix_pkg.sv ====
// shared types and constants for the HUB75 matrix driver
// pixel layout, scan position, write request and command opcodes
`default_nettype none

package led_matrix_pkg;

    localparam int PLANES = 2;   // bit planes per channel
    localparam int ADDR_W = 8;   // row and column fields are byte wide

    // command opcodes
    localparam logic [7:0] OP_WRITE  = 8'h57;
    localparam logic [7:0] OP_BRIGHT = 8'h42;
    localparam logic [7:0] OP_COLOR  = 8'h43;

    typedef logic [PLANES-1:0]         channel_t;
    typedef logic [PLANES-1:0]         plane_mask_t;
    typedef logic [$clog2(PLANES)-1:0] plane_t;
    typedef logic [2:0]                rgb_mask_t;   // bit 0 red, 1 green, 2 blue
    typedef logic [2:0]                rgb_out_t;    // same order as rgb_mask_t

    // red lands in bits 1:0, matching the write command's pixel byte
    typedef struct packed {
        channel_t blue;
        channel_t green;
        channel_t red;
    } pixel_t;

    typedef struct packed {
        pixel_t top;
        pixel_t bottom;
    } pixel_pair_t;

    typedef struct packed {
        logic [ADDR_W-1:0] col;
        logic [ADDR_W-1:0] row_pair;
        plane_t            plane;
    } scan_pos_t;

    typedef struct packed {
        logic              valid;
        logic              bank;       // 1 = bottom half
        logic [ADDR_W-1:0] row_pair;
        logic [ADDR_W-1:0] col;
        pixel_t            pixel;
    } wr_req_t;

endpackage

`default_nettype wire

// ==== cmd_decoder.sv ====
// command decoder, turns the strobed byte stream into frame writes
// and holds the colour and plane enable masks
`timescale 1ns/10ps
`default_nettype none

module cmd_decoder #(
    parameter int ROW_PAIRS = 16
) (
    input  logic                        clk_root,
    input  logic                        rst_n,
    input  logic [7:0]                  rx_byte,
    input  logic                        rx_strobe,
    output led_matrix_pkg::wr_req_t     wr_req,
    output led_matrix_pkg::rgb_mask_t   rgb_mask,
    output led_matrix_pkg::plane_mask_t plane_mask
);
    import led_matrix_pkg::*;

    localparam logic [ADDR_W-1:0] HALF_ROWS = ADDR_W'(ROW_PAIRS);

    logic [1:0]        byte_cnt;       // bytes of the current command seen
    logic [7:0]        opcode;
    logic [ADDR_W-1:0] row_q;
    logic [ADDR_W-1:0] col_q;
    logic              row_is_bottom;
    logic              wr_valid;
    logic              wr_bank;
    logic [ADDR_W-1:0] wr_row_pair;
    logic [ADDR_W-1:0] wr_col;
    pixel_t            wr_pixel;

    assign row_is_bottom = row_q >= HALF_ROWS;

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt   <= '0;
            opcode     <= '0;
            wr_valid   <= 1'b0;
            rgb_mask   <= '1;      // everything lit until told otherwise
            plane_mask <= '1;
        end else begin
            wr_valid <= 1'b0;
            if (rx_strobe) begin
                case (byte_cnt)
                    2'd0: begin
                        // unknown opcodes simply fall on the floor
                        if (rx_byte == OP_WRITE || rx_byte == OP_BRIGHT ||
                            rx_byte == OP_COLOR) begin
                            opcode   <= rx_byte;
                            byte_cnt <= 2'd1;
                        end
                    end
                    2'd1: begin
                        byte_cnt <= (opcode == OP_WRITE) ? 2'd2 : 2'd0;
                        if (opcode == OP_BRIGHT)
                            plane_mask <= rx_byte[PLANES-1:0];
                        if (opcode == OP_COLOR)
                            rgb_mask <= rx_byte[$bits(rgb_mask_t)-1:0];
                    end
                    2'd2: byte_cnt <= 2'd3;    // column byte
                    default: begin
                        byte_cnt <= 2'd0;      // pixel byte, fire the write
                        wr_valid <= 1'b1;
                    end
                endcase
            end
        end
    end

    // argument bytes and the outgoing write payload
    always_ff @(posedge clk_root) begin
        if (rx_strobe) begin
            if (byte_cnt == 2'd1)
                row_q <= rx_byte;
            if (byte_cnt == 2'd2)
                col_q <= rx_byte;
            if (byte_cnt == 2'd3) begin
                wr_bank     <= row_is_bottom;
                wr_row_pair <= row_is_bottom ? row_q - HALF_ROWS : row_q;
                wr_col      <= col_q;
                wr_pixel    <= pixel_t'(rx_byte[$bits(pixel_t)-1:0]);
            end
        end
    end

    assign wr_req = '{valid: wr_valid, bank: wr_bank, row_pair: wr_row_pair,
                      col: wr_col, pixel: wr_pixel};

endmodule

`default_nettype wire

// ==== frame_ram.sv ====
// frame memory, one bank per panel half
// single write port, strobed read returns the top/bottom pair
`timescale 1ns/10ps
`default_nettype none

module frame_ram #(
    parameter int COLS      = 64,
    parameter int ROW_PAIRS = 16
) (
    input  logic                        clk_root,
    input  led_matrix_pkg::wr_req_t     wr_req,
    input  led_matrix_pkg::scan_pos_t   rd_pos,
    input  logic                        rd_strobe,
    output led_matrix_pkg::pixel_pair_t rd_pair
);
    import led_matrix_pkg::*;

    localparam int DEPTH = ROW_PAIRS * COLS;
    localparam int A_W   = $clog2(DEPTH);

    pixel_t         mem [2][DEPTH];   // bank 0 top, bank 1 bottom
    pixel_t         rd_q [2];
    logic [A_W-1:0] wr_addr;
    logic [A_W-1:0] rd_addr;

    assign wr_addr = A_W'(wr_req.row_pair * COLS + wr_req.col);
    assign rd_addr = A_W'(rd_pos.row_pair * COLS + rd_pos.col);

    for (genvar b = 0; b < 2; b++) begin : g_bank
        always_ff @(posedge clk_root) begin
            if (wr_req.valid && wr_req.bank == b[0])
                mem[b][wr_addr] <= wr_req.pixel;
            if (rd_strobe)
                rd_q[b] <= mem[b][rd_addr];   // same address in both halves
        end
    end

    assign rd_pair = '{top: rd_q[0], bottom: rd_q[1]};

endmodule

`default_nettype wire

// ==== scan_timer.sv ====
// scan sequencer, divides clk_root into matrix ticks and steps
// shift, latch and display over columns, row pairs and planes
`timescale 1ns/10ps
`default_nettype none

module scan_timer #(
    parameter int COLS         = 64,
    parameter int ROW_PAIRS    = 16,
    parameter int TICK_DIV     = 4,
    parameter int DISPLAY_BASE = 8
) (
    input  logic                         clk_root,
    input  logic                         rst_n,
    output led_matrix_pkg::scan_pos_t    pos,
    output logic                         fetch,
    output logic                         clk_pixel,
    output logic                         row_latch,
    output logic                         output_enable,
    output logic [$clog2(ROW_PAIRS)-1:0] row_addr
);
    import led_matrix_pkg::*;

    localparam int C_W   = $clog2(COLS);
    localparam int RP_W  = $clog2(ROW_PAIRS);
    localparam int DIV_W = $clog2(TICK_DIV);
    localparam int ON_W  = $clog2(DISPLAY_BASE << (PLANES - 1)) + 1;

    localparam logic [2:0] PH_IDLE     = 3'd0;   // only right after reset
    localparam logic [2:0] PH_SHIFT_LO = 3'd1;   // column fetched, clock low
    localparam logic [2:0] PH_SHIFT_HI = 3'd2;
    localparam logic [2:0] PH_LATCH    = 3'd3;
    localparam logic [2:0] PH_DISPLAY  = 3'd4;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic [2:0]       phase;
    logic [C_W-1:0]   col_cnt;
    logic [RP_W-1:0]  row_cnt;
    plane_t           plane;
    logic [ON_W-1:0]  on_cnt;      // display ticks left
    logic [ON_W-1:0]  on_time;

    assign tick    = div_cnt == DIV_W'(TICK_DIV - 1);
    assign on_time = ON_W'(DISPLAY_BASE) << plane;   // binary weighting

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt       <= '0;
            phase         <= PH_IDLE;
            col_cnt       <= '0;
            row_cnt       <= '0;
            plane         <= '0;
            on_cnt        <= '0;
            fetch         <= 1'b0;
            clk_pixel     <= 1'b0;
            row_latch     <= 1'b0;
            output_enable <= 1'b0;
            row_addr      <= '0;
        end else begin
            fetch   <= 1'b0;
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                case (phase)
                    PH_IDLE: begin
                        fetch <= 1'b1;                 // column 0 of the first row
                        phase <= PH_SHIFT_LO;
                    end
                    PH_SHIFT_LO: begin
                        clk_pixel <= 1'b1;
                        phase     <= PH_SHIFT_HI;
                    end
                    PH_SHIFT_HI: begin
                        clk_pixel <= 1'b0;
                        if (col_cnt == C_W'(COLS - 1)) begin
                            row_latch <= 1'b1;
                            row_addr  <= row_cnt;      // the row just shifted in
                            phase     <= PH_LATCH;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                            fetch   <= 1'b1;
                            phase   <= PH_SHIFT_LO;
                        end
                    end
                    PH_LATCH: begin
                        row_latch     <= 1'b0;
                        output_enable <= 1'b1;
                        on_cnt        <= on_time - 1'b1;
                        phase         <= PH_DISPLAY;
                    end
                    PH_DISPLAY: begin
                        if (on_cnt == '0) begin
                            output_enable <= 1'b0;
                            col_cnt       <= '0;
                            fetch         <= 1'b1;     // next row starts shifting
                            phase         <= PH_SHIFT_LO;
                            if (row_cnt == RP_W'(ROW_PAIRS - 1)) begin
                                row_cnt <= '0;
                                plane   <= (plane == plane_t'(PLANES - 1)) ? '0 : plane + 1'b1;
                            end else begin
                                row_cnt <= row_cnt + 1'b1;
                            end
                        end else begin
                            on_cnt <= on_cnt - 1'b1;
                        end
                    end
                    default: phase <= PH_IDLE;
                endcase
            end
        end
    end

    assign pos = '{col: ADDR_W'(col_cnt), row_pair: ADDR_W'(row_cnt), plane: plane};

endmodule

`default_nettype wire

// ==== pixel_fetch.sv ====
// holds the pixel pair for the column being shifted
// plane index travels with the data through the memory latency
`timescale 1ns/10ps
`default_nettype none

module pixel_fetch (
    input  logic                        clk_root,
    input  logic                        rst_n,
    input  logic                        fetch,
    input  led_matrix_pkg::pixel_pair_t rd_pair,
    input  led_matrix_pkg::plane_t      plane,
    output led_matrix_pkg::pixel_pair_t pair,
    output led_matrix_pkg::plane_t      plane_q
);
    import led_matrix_pkg::*;

    logic   fetch_d;   // memory data valid this cycle
    plane_t plane_d;   // plane of the read in flight

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            fetch_d <= 1'b0;
            plane_d <= '0;
            pair    <= '0;      // panel sees black until the first column lands
            plane_q <= '0;
        end else begin
            fetch_d <= fetch;
            if (fetch)
                plane_d <= plane;
            if (fetch_d) begin
                pair    <= rd_pair;
                plane_q <= plane_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bitplane_select.sv ====
// picks the current plane's bit from both pixels
// and gates it with the colour and plane enables
`timescale 1ns/10ps
`default_nettype none

module bitplane_select (
    input  led_matrix_pkg::pixel_pair_t pair,
    input  led_matrix_pkg::plane_t      plane,
    input  led_matrix_pkg::rgb_mask_t   rgb_mask,
    input  led_matrix_pkg::plane_mask_t plane_mask,
    output led_matrix_pkg::rgb_out_t    rgb_top,
    output led_matrix_pkg::rgb_out_t    rgb_bottom
);
    import led_matrix_pkg::*;

    rgb_out_t gate;   // channels allowed to light in this plane

    // one bit per channel, red in bit 0
    function automatic rgb_out_t plane_bits(input pixel_t px, input plane_t pl);
        return {px.blue[pl], px.green[pl], px.red[pl]};
    endfunction

    assign gate = rgb_mask & {$bits(rgb_out_t){plane_mask[plane]}};

    assign rgb_top    = plane_bits(pair.top, plane) & gate;
    assign rgb_bottom = plane_bits(pair.bottom, plane) & gate;

endmodule

`default_nettype wire

// ==== led_matrix_top.sv ====
// HUB75 matrix driver top level
// command decoder, frame memory and the scan pipeline to the panel pins
`timescale 1ns/10ps
`default_nettype none

module led_matrix_top #(
    parameter int COLS         = 64,
    parameter int ROW_PAIRS    = 16,
    parameter int TICK_DIV     = 4,    // at least 2
    parameter int DISPLAY_BASE = 8     // plane 0 on-time in ticks
) (
    input  logic                         clk_root,
    input  logic                         rst_n,
    input  logic [7:0]                   rx_byte,
    input  logic                         rx_strobe,
    output led_matrix_pkg::rgb_out_t     rgb_top,
    output led_matrix_pkg::rgb_out_t     rgb_bottom,
    output logic                         clk_pixel,
    output logic                         row_latch,
    output logic                         output_enable,
    output logic [$clog2(ROW_PAIRS)-1:0] row_addr
);
    import led_matrix_pkg::*;

    wr_req_t     wr_req;
    rgb_mask_t   rgb_mask;
    plane_mask_t plane_mask;
    scan_pos_t   pos;
    logic        fetch;
    pixel_pair_t rd_pair;
    pixel_pair_t pair;       // column currently on the shift pins
    plane_t      plane_q;

    cmd_decoder #(
        .ROW_PAIRS (ROW_PAIRS)
    ) u_cmd_decoder (
        .clk_root   (clk_root),
        .rst_n      (rst_n),
        .rx_byte    (rx_byte),
        .rx_strobe  (rx_strobe),
        .wr_req     (wr_req),
        .rgb_mask   (rgb_mask),
        .plane_mask (plane_mask)
    );

    frame_ram #(
        .COLS      (COLS),
        .ROW_PAIRS (ROW_PAIRS)
    ) u_frame_ram (
        .clk_root  (clk_root),
        .wr_req    (wr_req),
        .rd_pos    (pos),
        .rd_strobe (fetch),
        .rd_pair   (rd_pair)
    );

    scan_timer #(
        .COLS         (COLS),
        .ROW_PAIRS    (ROW_PAIRS),
        .TICK_DIV     (TICK_DIV),
        .DISPLAY_BASE (DISPLAY_BASE)
    ) u_scan_timer (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .pos           (pos),
        .fetch         (fetch),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .output_enable (output_enable),
        .row_addr      (row_addr)
    );

    pixel_fetch u_pixel_fetch (
        .clk_root (clk_root),
        .rst_n    (rst_n),
        .fetch    (fetch),
        .rd_pair  (rd_pair),
        .plane    (pos.plane),
        .pair     (pair),
        .plane_q  (plane_q)
    );

    bitplane_select u_bitplane_select (
        .pair       (pair),
        .plane      (plane_q),
        .rgb_mask   (rgb_mask),
        .plane_mask (plane_mask),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom)
    );

endmodule

`default_nettype wire

// ==== tb_led_matrix.sv ====
// testbench for the HUB75 matrix driver
// fills the frame over the byte stream and checks each shifted row in a panel model
`timescale 1ns/10ps
`default_nettype none

module tb_led_matrix;
    import led_matrix_pkg::*;

    localparam int COLS         = 8;
    localparam int ROW_PAIRS    = 4;
    localparam int TICK_DIV     = 4;
    localparam int DISPLAY_BASE = 8;
    localparam int NUM_TESTS    = 5;
    localparam int FRAME_ROWS   = 2 * ROW_PAIRS;   // latches per frame
    localparam logic [31:0] LCG_SEED = 32'h9d33_63ac;

    // two cycles per byte including strays and mask commands
    localparam int WR_CYCLES    = 2 * (4 * FRAME_ROWS * COLS + FRAME_ROWS + 8);
    localparam int FRAME_CYCLES = TICK_DIV * ROW_PAIRS *
                                  (PLANES * (2 * COLS + 2) + DISPLAY_BASE * ((1 << PLANES) - 1));
    localparam int CYCLE_LIMIT  = NUM_TESTS * (WR_CYCLES + 3 * FRAME_CYCLES) + 2000;

    typedef struct packed {
        logic [31:0] seed;
        rgb_mask_t   rgb_mask;
        plane_mask_t plane_mask;
        logic        stray;      // unknown opcodes mixed into the stream
    } entry_t;

    logic                         clk_root;
    logic                         rst_n;
    logic [7:0]                   rx_byte;
    logic                         rx_strobe;
    rgb_out_t                     rgb_top;
    rgb_out_t                     rgb_bottom;
    logic                         clk_pixel;
    logic                         row_latch;
    logic                         output_enable;
    logic [$clog2(ROW_PAIRS)-1:0] row_addr;

    entry_t      tests [NUM_TESTS];
    logic [5:0]  ref_frame [FRAME_ROWS][COLS];   // rows ROW_PAIRS and up are the bottom half
    rgb_mask_t   exp_rgb_mask;
    plane_mask_t exp_plane_mask;
    rgb_out_t    samp_top [COLS];
    rgb_out_t    samp_bottom [COLS];
    int          errors;
    int          checks;
    int          rows_checked;
    int          latch_count;    // latches since reset
    int          col_idx;
    int          oe_len;
    int          last_plane;
    int          cycles;
    logic        check_en;
    logic        clk_pixel_q;
    logic        row_latch_q;
    logic        output_enable_q;

    led_matrix_top #(
        .COLS         (COLS),
        .ROW_PAIRS    (ROW_PAIRS),
        .TICK_DIV     (TICK_DIV),
        .DISPLAY_BASE (DISPLAY_BASE)
    ) DUT (
        .clk_root      (clk_root),
        .rst_n         (rst_n),
        .rx_byte       (rx_byte),
        .rx_strobe     (rx_strobe),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .output_enable (output_enable),
        .row_addr      (row_addr)
    );

    initial begin
        clk_root = 1'b0;
        forever #20 clk_root = ~clk_root;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // pixel byte has red in 1:0, green in 3:2, blue in 5:4
    function automatic rgb_out_t expected_bits(input logic [5:0] px, input int pl);
        rgb_out_t bits;
        for (int ch = 0; ch < 3; ch++)
            bits[ch] = px[2*ch + pl] & exp_rgb_mask[ch] & exp_plane_mask[pl];
        return bits;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got=%h exp=%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk_root);
        #2;
        rx_byte   = b;
        rx_strobe = 1'b1;
        @(posedge clk_root);
        #2;
        rx_strobe = 1'b0;
    endtask

    task automatic send_write(input int row, input int col, input logic [5:0] px);
        send_byte(OP_WRITE);
        send_byte(8'(row));
        send_byte(8'(col));
        send_byte({2'b00, px});
    endtask

    // on each latch the shifted columns are checked against the reference
    task automatic latch_row();
        int row;
        int pl;
        row = latch_count % ROW_PAIRS;
        pl  = (latch_count / ROW_PAIRS) % PLANES;
        compare("row_addr", row_addr, row);
        compare("clk_pixel rises per latch", col_idx, COLS);
        if (check_en) begin
            for (int c = 0; c < COLS; c++) begin
                compare("rgb_top", samp_top[c], expected_bits(ref_frame[row][c], pl));
                compare("rgb_bottom", samp_bottom[c],
                        expected_bits(ref_frame[row + ROW_PAIRS][c], pl));
            end
            rows_checked++;
        end
        col_idx    = 0;
        last_plane = pl;
        latch_count++;
    endtask

    // panel model samples on the falling edge
    always @(negedge clk_root) begin
        if (rst_n) begin
            compare("output_enable overlap", output_enable & (clk_pixel | row_latch), 0);
            if (clk_pixel && !clk_pixel_q) begin
                if (col_idx < COLS) begin
                    samp_top[col_idx]    = rgb_top;
                    samp_bottom[col_idx] = rgb_bottom;
                end
                col_idx++;
            end
            if (row_latch && !row_latch_q)
                latch_row();
            if (output_enable) begin
                oe_len++;
            end else if (output_enable_q) begin
                compare("output_enable cycles", oe_len, (DISPLAY_BASE * TICK_DIV) << last_plane);
                oe_len = 0;
            end
        end
        clk_pixel_q     = clk_pixel;
        row_latch_q     = row_latch;
        output_enable_q = output_enable;
    end

    always @(posedge clk_root) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout, run still going after %0d clock cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int          target;
        logic [31:0] state;
        logic [5:0]  px;
        tests[0] = '{seed: 32'h0000_0000, rgb_mask: 3'b111, plane_mask: 2'b11, stray: 1'b0};
        tests[1] = '{seed: 32'h0000_1234, rgb_mask: 3'b001, plane_mask: 2'b11, stray: 1'b0};
        tests[2] = '{seed: 32'h0000_5a5a, rgb_mask: 3'b111, plane_mask: 2'b01, stray: 1'b0};
        tests[3] = '{seed: 32'h0001_0001, rgb_mask: 3'b111, plane_mask: 2'b11, stray: 1'b1};
        tests[4] = '{seed: 32'h00c0_ffee, rgb_mask: 3'b110, plane_mask: 2'b10, stray: 1'b0};
        rst_n           = 1'b0;
        rx_byte         = 8'h00;
        rx_strobe       = 1'b0;
        errors          = 0;
        checks          = 0;
        rows_checked    = 0;
        latch_count     = 0;
        col_idx         = 0;
        oe_len          = 0;
        last_plane      = 0;
        cycles          = 0;
        check_en        = 1'b0;
        clk_pixel_q     = 1'b0;
        row_latch_q     = 1'b0;
        output_enable_q = 1'b0;
        exp_rgb_mask    = '1;
        exp_plane_mask  = '1;
        repeat (8) @(posedge clk_root);
        #2;
        rst_n = 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            state = LCG_SEED + tests[t].seed;
            for (int r = 0; r < FRAME_ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    state = lcg_next(state);
                    px    = state[21:16];
                    ref_frame[r][c] = px;
                    send_write(r, c, px);
                    if (tests[t].stray && c == 3)
                        send_byte(8'ha5);   // not an opcode
                end
            end
            send_byte(OP_COLOR);
            send_byte({5'b0, tests[t].rgb_mask});
            if (tests[t].stray)
                send_byte(8'h00);
            send_byte(OP_BRIGHT);
            send_byte({6'b0, tests[t].plane_mask});
            exp_rgb_mask   = tests[t].rgb_mask;
            exp_plane_mask = tests[t].plane_mask;

            // wait for the next frame boundary and check one whole frame
            target = (latch_count / FRAME_ROWS + 1) * FRAME_ROWS;
            wait (latch_count >= target);
            check_en = 1'b1;
            wait (latch_count >= target + FRAME_ROWS);
            check_en = 1'b0;
        end

        $display("errors=%0d checks=%0d rows_checked=%0d latches=%0d",
                 errors, checks, rows_checked, latch_count);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
led_matrix_pkg.sv
cmd_decoder.sv
frame_ram.sv
scan_timer.sv
pixel_fetch.sv
bitplane_select.sv
led_matrix_top.sv
tb_led_matrix.sv

// ==== Bender.yml ====
package:
  name: led_matrix

sources:
  - led_matrix_pkg.sv
  - cmd_decoder.sv
  - frame_ram.sv
  - scan_timer.sv
  - pixel_fetch.sv
  - bitplane_select.sv
  - led_matrix_top.sv
  - target: simulation
    files:
      - tb_led_matrix.sv
